/* Makefile */
# Verilator build and run for the hub command router.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= mopshub_route_tb
FILELIST  ?= mopshub_route.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/mopshub_defs.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulator output goes to the log, and the log decides pass or fail.
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mopshub_route_tb.sv */
//----------------------------------------------------------------------------
// Testbench for the hub command router, with a reference model and checker.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

module mopshub_route_tb;

  import hub_cmd_pkg::*;
  import bus_lane_pkg::*;

  localparam int n_bus = `MOPSHUB_NUM_BUS;

  logic             clk;
  logic             reset;
  hub_cmd_t         cmd;
  logic             cmd_strobe;
  logic             cmd_busy;
  logic [n_bus-1:0] tx_valid;
  lane_word_t       tx_word [n_bus];
  logic [n_bus-1:0] tx_ready;
  logic [n_bus-1:0] rx_valid = '0;
  lane_word_t       rx_word [n_bus] = '{default: '0};
  logic [n_bus-1:0] rx_grant;
  hub_resp_t        resp;
  logic             resp_strobe;

  int                         seed = 32'h4489;
  int                         errors = 0;
  logic [`MOPSHUB_WORD_W-1:0] tx_exp_q [n_bus][$];  // Words each bus still has to take.
  hub_resp_t                  resp_exp_q [$];
  int                         rr_ptr = 0;
  logic                       resp_due = 1'b0;
  logic [n_bus-1:0]           granted = '0;
  int                         rx_rate = 0;  // Percent chance per idle lane per cycle.
  int                         words_sent = 0;
  int                         resp_count = 0;
  int                         grant_count = 0;
  int                         cmd_count = 0;

  mopshub_route mopshub_route_i (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .cmd_strobe  (cmd_strobe),
    .cmd_busy    (cmd_busy),
    .tx_valid    (tx_valid),
    .tx_word     (tx_word),
    .tx_ready    (tx_ready),
    .rx_valid    (rx_valid),
    .rx_word     (rx_word),
    .rx_grant    (rx_grant),
    .resp        (resp),
    .resp_strobe (resp_strobe)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A command goes to the lane named by its bus number, data unchanged.
  function automatic lane_word_t route_word(hub_cmd_t c, output int lane);
    lane_word_t w;
    lane   = int'(c.bus_id);
    w.data = c.data;
    return w;
  endfunction

  // First requesting lane at or after the pointer, or -1 if none requests.
  function automatic int next_winner(logic [n_bus-1:0] valid, int ptr);
    int lane;
    for (int k = 0; k < n_bus; k++)
    begin
      lane = (ptr + k) % n_bus;
      if (valid[lane])
        return lane;
    end
    return -1;
  endfunction

  function automatic bit model_idle();
    for (int i = 0; i < n_bus; i++)
    begin
      if (tx_exp_q[i].size() != 0)
        return 1'b0;
    end
    return (rx_valid == '0) && (resp_exp_q.size() == 0) && !resp_due;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    errors++;
  endtask

  task automatic pulse_cmd(int bus, logic [15:0] data, output logic busy_seen);
    @(negedge clk);
    cmd.bus_id = `MOPSHUB_SEL_W'(bus);
    cmd.data   = data;
    cmd_strobe = 1'b1;
    @(posedge clk);
    busy_seen = cmd_busy;
    @(negedge clk);
    cmd_strobe = 1'b0;
  endtask

  task automatic wait_lane(int lane, logic level, int limit);
    int n;
    n = 0;
    while ((tx_valid[lane] !== level) && (n < limit))
    begin
      @(negedge clk);
      n++;
    end
    if (tx_valid[lane] !== level)
    begin
      $display("Timeout: tx_valid of lane %0d did not reach %0b", lane, level);
      errors++;
    end
  endtask

  task automatic wait_settled(int limit);
    int n;
    n = 0;
    while (!model_idle() && (n < limit))
    begin
      @(negedge clk);
      n++;
    end
    if (!model_idle())
    begin
      $display("Timeout: traffic still pending after %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic check_counts(string name);
    if (resp_count != words_sent)
      report_mismatch({name, " responses"}, 32'(words_sent), 32'(resp_count));
    if (grant_count != words_sent)
      report_mismatch({name, " grants"}, 32'(words_sent), 32'(grant_count));
  endtask

  // Checker. Compares the DUT against the model on every rising edge, then advances it.
  always @(posedge clk)
  begin
    int               win;
    int               lane;
    logic             exp_busy;
    logic [n_bus-1:0] exp_grant;
    lane_word_t       word;
    hub_resp_t        exp_resp;
    if (!reset)
    begin
      for (int i = 0; i < n_bus; i++)
      begin
        if (tx_valid[i] !== (tx_exp_q[i].size() != 0))
          report_mismatch($sformatf("tx_valid[%0d]", i),
                          32'(tx_exp_q[i].size() != 0), 32'(tx_valid[i]));
        else if (tx_valid[i] && (tx_word[i].data !== tx_exp_q[i][0]))
          report_mismatch($sformatf("tx_word[%0d]", i),
                          32'(tx_exp_q[i][0]), 32'(tx_word[i].data));
      end
      exp_busy = (tx_exp_q[cmd.bus_id].size() != 0) && !tx_ready[cmd.bus_id];
      if (cmd_busy !== exp_busy)
        report_mismatch("cmd_busy", 32'(exp_busy), 32'(cmd_busy));
      for (int i = 0; i < n_bus; i++)
      begin
        if ((tx_exp_q[i].size() != 0) && tx_ready[i])
          void'(tx_exp_q[i].pop_front());
      end
      if (cmd_strobe && !exp_busy)
      begin
        word = route_word(cmd, lane);
        tx_exp_q[lane].push_back(word.data);
        cmd_count++;
      end

      if (resp_strobe !== resp_due)
        report_mismatch("resp_strobe", 32'(resp_due), 32'(resp_strobe));
      else if (resp_strobe)
      begin
        exp_resp = resp_exp_q.pop_front();
        if (resp !== exp_resp)
          report_mismatch("resp", 32'(exp_resp), 32'(resp));
        resp_count++;
      end
      win       = next_winner(rx_valid, rr_ptr);
      exp_grant = '0;
      if (win >= 0)
        exp_grant[win] = 1'b1;
      if (rx_grant !== exp_grant)
        report_mismatch("rx_grant", 32'(exp_grant), 32'(rx_grant));
      if (win >= 0)
      begin
        exp_resp.bus_id = `MOPSHUB_SEL_W'(win);
        exp_resp.data   = rx_word[win].data;
        resp_exp_q.push_back(exp_resp);
        rr_ptr = (win + 1) % n_bus;
      end
      resp_due    = (win >= 0);
      granted     = rx_grant;
      grant_count += $countones(rx_grant);
    end
  end

  // Bus side of the response path. A lane holds its request until granted.
  always @(negedge clk)
  begin
    if (!reset)
    begin
      for (int i = 0; i < n_bus; i++)
      begin
        if (granted[i])
          rx_valid[i] = 1'b0;
        else if (!rx_valid[i] && (rx_rate > 0)
                 && (($unsigned($random(seed)) % 100) < rx_rate))
        begin
          rx_valid[i]     = 1'b1;
          rx_word[i].data = 16'($random(seed));
          words_sent++;
        end
      end
    end
  end

  initial
  begin
    logic             busy;
    logic [n_bus-1:0] onehot;
    logic [15:0]      word_a;
    logic [15:0]      word_c;
    cmd        = '0;
    cmd_strobe = 1'b0;
    tx_ready   = '0;
    reset      = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    if (tx_valid !== '0)
      report_mismatch("reset tx_valid", 32'd0, 32'(tx_valid));
    if (rx_grant !== '0)
      report_mismatch("reset rx_grant", 32'd0, 32'(rx_grant));
    if (cmd_busy !== 1'b0)
      report_mismatch("reset cmd_busy", 32'd0, 32'(cmd_busy));
    if (resp_strobe !== 1'b0)
      report_mismatch("reset resp_strobe", 32'd0, 32'(resp_strobe));

    @(negedge clk);
    tx_ready = '1;
    for (int b = 0; b < n_bus; b++)
    begin
      word_a = 16'($random(seed));
      pulse_cmd(b, word_a, busy);
      wait_lane(b, 1'b1, 8);
      onehot    = '0;
      onehot[b] = 1'b1;
      if (tx_valid !== onehot)
        report_mismatch("routing tx_valid", 32'(onehot), 32'(tx_valid));
      if (tx_word[b].data !== word_a)
        report_mismatch("routing tx_word", 32'(word_a), 32'(tx_word[b].data));
    end

    // Lane 5 stalls while lane 9 keeps moving.
    @(negedge clk);
    tx_ready[5] = 1'b0;
    word_a = 16'($random(seed));
    word_c = 16'($random(seed));
    pulse_cmd(5, word_a, busy);
    wait_lane(5, 1'b1, 8);
    pulse_cmd(5, ~word_a, busy);  // Dropped, since lane 5 is still full.
    if (busy !== 1'b1)
      report_mismatch("busy on held lane", 32'd1, 32'(busy));
    pulse_cmd(9, word_c, busy);
    if (busy !== 1'b0)
      report_mismatch("busy on free lane", 32'd0, 32'(busy));
    wait_lane(9, 1'b1, 8);
    if (tx_word[5].data !== word_a)
      report_mismatch("held word", 32'(word_a), 32'(tx_word[5].data));
    @(negedge clk);
    tx_ready[5] = 1'b1;
    wait_lane(5, 1'b0, 8);

    rx_rate = 30;
    repeat (150) @(negedge clk);
    rx_rate = 0;
    wait_settled(400);
    check_counts("merge");

    rx_rate = 8;
    for (int n = 0; n < 400; n++)
    begin
      @(negedge clk);
      tx_ready   = $random(seed);
      cmd.bus_id = `MOPSHUB_SEL_W'($random(seed));
      cmd.data   = 16'($random(seed));
      cmd_strobe = 1'($random(seed));
    end
    @(negedge clk);
    cmd_strobe = 1'b0;
    tx_ready   = '1;
    rx_rate    = 0;
    wait_settled(600);
    check_counts("mixed");

    $display("Errors: %0d, commands: %0d, responses: %0d, grants: %0d",
             errors, cmd_count, resp_count, grant_count);
    if (errors == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/bus_lane_pkg.sv */
//----------------------------------------------------------------------------
// Bus-side word format carried on each of the hub lanes.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

package bus_lane_pkg;

  // One word on a single lane. The bus number is implied by the lane
  // index, so only the payload travels here.
  typedef struct packed {
    logic [`MOPSHUB_WORD_W-1:0] data;
  } lane_word_t;

endpackage

`default_nettype wire

/* logic/hub_cmd_pkg.sv */
//----------------------------------------------------------------------------
// Host-side word formats for commands and tagged responses.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

package hub_cmd_pkg;

  // Command word from the host, steered to the lane named by bus_id.
  typedef struct packed {
    logic [`MOPSHUB_SEL_W-1:0]  bus_id;
    logic [`MOPSHUB_WORD_W-1:0] data;
  } hub_cmd_t;

  // Response word going back to the host, tagged with its source bus.
  typedef struct packed {
    logic [`MOPSHUB_SEL_W-1:0]  bus_id;
    logic [`MOPSHUB_WORD_W-1:0] data;
  } hub_resp_t;

endpackage

`default_nettype wire

/* logic/lane_demux.sv */
//----------------------------------------------------------------------------
// 1-to-N demultiplexer; the selected lane gets the payload, all others zero.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

module lane_demux #(
  parameter type payload_t = logic,
  parameter int  n_lanes   = `MOPSHUB_NUM_BUS
) (
  input  logic [`MOPSHUB_SEL_W-1:0] sel,
  input  logic                      enable,
  input  payload_t                  payload,
  output payload_t                  lanes [n_lanes],
  output logic [n_lanes-1:0]        hit
);

  always_comb
  begin
    for (int i = 0; i < n_lanes; i++)
    begin
      lanes[i] = '0;  // Unselected lanes stay at zero.
    end
    hit = '0;
    if (enable)
    begin
      lanes[sel] = payload;
      hit[sel]   = 1'b1;
    end
  end

  // The load and grant vectors downstream rely on at most one lane
  // being hit, and on none at all while the demultiplexer is idle.
  always_comb
  begin
    hit_onehot_a : assert final ($onehot0(hit) && (enable || (hit == '0)))
      else $error("lane_demux hit vector 0x%0h with enable %0b", hit, enable);
  end

endmodule

`default_nettype wire

/* logic/lane_tx_buffer.sv */
//----------------------------------------------------------------------------
// One-word transmit buffer per lane, held until the bus raises ready.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

module lane_tx_buffer #(
  parameter int n_lanes = `MOPSHUB_NUM_BUS
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [n_lanes-1:0]       load,
  input  bus_lane_pkg::lane_word_t load_word [n_lanes],
  input  logic [n_lanes-1:0]       tx_ready,
  output logic [n_lanes-1:0]       tx_valid,
  output bus_lane_pkg::lane_word_t tx_word [n_lanes],
  output logic [n_lanes-1:0]       full
);

  logic [n_lanes-1:0] drain;

  assign drain = tx_valid & tx_ready;  // Bus takes the word on this edge.

  // A lane that drains on this edge can take a new word on the same edge,
  // so it does not report full.
  assign full = tx_valid & ~drain;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_valid <= '0;
    end
    else
    begin
      tx_valid <= load | (tx_valid & ~drain);  // A load wins over a drain.
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < n_lanes; i++)
    begin
      if (load[i])
      begin
        tx_word[i] <= load_word[i];
      end
    end
  end

  // The top level blocks commands to full lanes through cmd_busy.
  // A load into a held word would overwrite it before the bus saw it.
  load_into_full_a : assert property (
    @(posedge clk) disable iff (reset)
    (load & full) == '0
  ) else $error("lane_tx_buffer load 0x%0h into full lanes 0x%0h", load, full);

endmodule

`default_nettype wire

/* logic/mopshub_defs.svh */
//----------------------------------------------------------------------------
// Hub sizing for the command router.
// Bus count, bus number width and payload word width.
//----------------------------------------------------------------------------

`ifndef MOPSHUB_DEFS_SVH
`define MOPSHUB_DEFS_SVH

// Number of CAN-side front ends served by the hub.
`define MOPSHUB_NUM_BUS 32

// Width of a bus number, enough to name every lane.
`define MOPSHUB_SEL_W 5

`define MOPSHUB_WORD_W 16  // Payloads are opaque words.

`endif

/* logic/mopshub_route.sv */
//----------------------------------------------------------------------------
// Hub command router; host commands out to the lanes, lane responses back.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

module mopshub_route (
  input  logic                                clk,
  input  logic                                reset,
  input  hub_cmd_pkg::hub_cmd_t               cmd,
  input  logic                                cmd_strobe,
  output logic                                cmd_busy,
  output logic [`MOPSHUB_NUM_BUS-1:0]         tx_valid,
  output bus_lane_pkg::lane_word_t            tx_word [`MOPSHUB_NUM_BUS],
  input  logic [`MOPSHUB_NUM_BUS-1:0]         tx_ready,
  input  logic [`MOPSHUB_NUM_BUS-1:0]         rx_valid,
  input  bus_lane_pkg::lane_word_t            rx_word [`MOPSHUB_NUM_BUS],
  output logic [`MOPSHUB_NUM_BUS-1:0]         rx_grant,
  output hub_cmd_pkg::hub_resp_t              resp,
  output logic                                resp_strobe
);

  import bus_lane_pkg::*;

  localparam int n_bus = `MOPSHUB_NUM_BUS;

  lane_word_t                 cmd_word;
  lane_word_t                 cmd_lanes [n_bus];
  logic [n_bus-1:0]           cmd_load;
  logic [n_bus-1:0]           buf_full;
  logic                       cmd_accept;
  logic [`MOPSHUB_SEL_W-1:0]  grant_sel;
  logic                       grant_strobe;

  // Busy only reflects the lane this command is aimed at.
  assign cmd_busy   = buf_full[cmd.bus_id];
  assign cmd_accept = cmd_strobe & ~cmd_busy;  // Strobes while busy are dropped.
  assign cmd_word   = '{data: cmd.data};

  lane_demux #(
    .payload_t (lane_word_t),
    .n_lanes   (n_bus)
  ) cmd_demux_i (
    .sel     (cmd.bus_id),
    .enable  (cmd_accept),
    .payload (cmd_word),
    .lanes   (cmd_lanes),
    .hit     (cmd_load)
  );

  lane_tx_buffer #(
    .n_lanes (n_bus)
  ) tx_buffer_i (
    .clk       (clk),
    .reset     (reset),
    .load      (cmd_load),
    .load_word (cmd_lanes),
    .tx_ready  (tx_ready),
    .tx_valid  (tx_valid),
    .tx_word   (tx_word),
    .full      (buf_full)
  );

  response_arbiter #(
    .n_lanes (n_bus)
  ) arbiter_i (
    .clk          (clk),
    .reset        (reset),
    .rx_valid     (rx_valid),
    .rx_word      (rx_word),
    .grant_sel    (grant_sel),
    .grant_strobe (grant_strobe),
    .resp         (resp),
    .resp_strobe  (resp_strobe)
  );

  // Only the hit vector matters here. It is the per-bus grant pulse.
  lane_demux #(
    .payload_t (logic),
    .n_lanes   (n_bus)
  ) grant_demux_i (
    .sel     (grant_sel),
    .enable  (grant_strobe),
    .payload (grant_strobe),
    .lanes   (),
    .hit     (rx_grant)
  );

endmodule

`default_nettype wire

/* logic/response_arbiter.sv */
//----------------------------------------------------------------------------
// Round-robin merge of N response lanes into one bus-tagged stream.
//----------------------------------------------------------------------------

`default_nettype none

`include "mopshub_defs.svh"

module response_arbiter #(
  parameter int n_lanes = `MOPSHUB_NUM_BUS
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [n_lanes-1:0]        rx_valid,
  input  bus_lane_pkg::lane_word_t  rx_word [n_lanes],
  output logic [`MOPSHUB_SEL_W-1:0] grant_sel,
  output logic                      grant_strobe,
  output hub_cmd_pkg::hub_resp_t    resp,
  output logic                      resp_strobe
);

  import hub_cmd_pkg::*;

  localparam int sel_w = `MOPSHUB_SEL_W;

  logic [sel_w-1:0] ptr_q;  // First lane to look at this cycle.
  logic [sel_w-1:0] win_sel;
  logic             win_found;
  hub_resp_t        resp_next;

  // Scan from the far end back towards the pointer so that the lane
  // closest after the pointer is the one left standing.
  always_comb
  begin
    int idx;
    win_found = 1'b0;
    win_sel   = '0;
    for (int k = n_lanes - 1; k >= 0; k--)
    begin
      idx = (int'(ptr_q) + k) % n_lanes;
      if (rx_valid[idx])
      begin
        win_found = 1'b1;
        win_sel   = sel_w'(idx);
      end
    end
  end

  // Grant goes out in the decision cycle, so the bus drops rx_valid
  // at the same edge that captures its word.
  assign grant_sel    = win_sel;
  assign grant_strobe = win_found;

  assign resp_next = '{bus_id: win_sel, data: rx_word[win_sel].data};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr_q       <= '0;
      resp_strobe <= 1'b0;
    end
    else
    begin
      resp_strobe <= win_found;
      if (win_found)
      begin
        ptr_q <= (win_sel == sel_w'(n_lanes - 1)) ? '0 : win_sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (win_found)
    begin
      resp <= resp_next;
    end
  end

  // A response always traces back to a lane that was requesting one cycle earlier.
  resp_has_request_a : assert property (
    @(posedge clk) disable iff (reset)
    resp_strobe |-> $past(|rx_valid)
  ) else $error("response_arbiter strobe without a request");

endmodule

`default_nettype wire

/* mopshub_route.f */
+incdir+logic
logic/hub_cmd_pkg.sv
logic/bus_lane_pkg.sv
logic/lane_demux.sv
logic/lane_tx_buffer.sv
logic/response_arbiter.sv
logic/mopshub_route.sv
dv/mopshub_route_tb.sv
